/* hw/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	// --------------------
	// Operation codes
	// --------------------

	// Same numbering as the original ALU opcode field
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_OR  = 3'd1,
		OP_NOT = 3'd2,
		OP_DAA = 3'd3,
		OP_AND = 3'd4,
		OP_CLD = 3'd5,
		OP_CMP = 3'd6,
		OP_STD = 3'd7
	} alu_op_t;

	// Operand size, encoding 3 is illegal
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WORD  = 2'd1,
		SZ_DWORD = 2'd2
	} data_size_t;

	// --------------------
	// Flag bit positions
	// --------------------

	// Positions inside the 32-bit flags word
	localparam int FLAG_CF = 0;
	localparam int FLAG_PF = 2;
	localparam int FLAG_AF = 4;
	localparam int FLAG_ZF = 6;
	localparam int FLAG_SF = 7;
	localparam int FLAG_DF = 10;
	localparam int FLAG_OF = 11;

	// --------------------
	// Request payload
	// --------------------

	// One execute request, 69 bits
	typedef struct packed {
		alu_op_t    op;
		data_size_t size;
		logic [31:0] a;
		logic [31:0] b;
	} exe_req_t;

endpackage

`default_nettype wire

/* hw/exe_if.sv */
`default_nettype none

// Request channel into the execute stage
interface exe_req_if (
	input wire logic clk
);
	import alu_pkg::*;

	logic     valid;
	logic     ready;
	// Payload is only meaningful while valid is high
	exe_req_t payload;

	// Source holds valid and payload until ready
	modport source (input clk, input ready, output valid, output payload);
	modport sink (input clk, input valid, input payload, output ready);
endinterface

// Combinational ALU bus, no handshake
interface alu_if;
	import alu_pkg::*;

	alu_op_t     op;
	data_size_t  size;
	logic [31:0] a;
	logic [31:0] b;
	// Carry and aux carry from the previous operation, used by DAA
	logic        cf_in;
	logic        af_in;
	// Full architectural flags, for ops that keep untouched bits
	logic [31:0] flags_in;
	logic [31:0] result;
	logic [31:0] flags;

	modport alu (input op, size, a, b, cf_in, af_in, flags_in, output result, flags);
	modport stage (output op, size, a, b, cf_in, af_in, flags_in, input result, flags);
endinterface

`default_nettype wire

/* hw/alu_arith.sv */
`default_nettype none

module alu_arith (
	input  wire logic [31:0]        a,
	input  wire logic [31:0]        b,
	input  wire logic               subtract,
	input  wire alu_pkg::data_size_t size,
	output logic [31:0]             sum,
	output logic                    cf,
	output logic                    af,
	output logic                    of
);
	import alu_pkg::*;

	// Second operand after optional inversion
	logic [31:0] b_eff;
	// Full sum with carry out of bit 31
	logic [32:0] full;
	// Carries out of the byte, word and dword tops
	logic        c8;
	logic        c16;
	logic        c32;
	// Size-selected carry and sign bits
	logic        carry_top;
	logic        sign_a;
	logic        sign_b;
	logic        sign_r;

	// --------------------
	// Adder
	// --------------------

	// Subtract as a plus inverted b plus one
	assign b_eff = subtract ? ~b : b;
	assign full  = {1'b0, a} + {1'b0, b_eff} + {32'd0, subtract};
	assign sum   = full[31:0];

	// Carry into bit i recovered from the sum bit
	assign c8  = sum[8] ^ a[8] ^ b_eff[8];
	assign c16 = sum[16] ^ a[16] ^ b_eff[16];
	assign c32 = full[32];

	// Aux carry or borrow out of bit 3, same form for add and subtract
	assign af = sum[4] ^ a[4] ^ b[4];

	// --------------------
	// Size select
	// --------------------

	always_comb begin
		case (size)
			SZ_BYTE: begin
				carry_top = c8;
				sign_a    = a[7];
				sign_b    = b_eff[7];
				sign_r    = sum[7];
			end
			SZ_WORD: begin
				carry_top = c16;
				sign_a    = a[15];
				sign_b    = b_eff[15];
				sign_r    = sum[15];
			end
			default: begin
				carry_top = c32;
				sign_a    = a[31];
				sign_b    = b_eff[31];
				sign_r    = sum[31];
			end
		endcase
	end

	// Borrow is the inverted carry when subtracting
	assign cf = carry_top ^ subtract;

	// Same-sign inputs giving an opposite-sign result
	assign of = (sign_a == sign_b) && (sign_r != sign_a);

endmodule

`default_nettype wire

/* hw/alu_daa.sv */
`default_nettype none

module alu_daa (
	input  wire logic [7:0] al,
	input  wire logic       cf_in,
	input  wire logic       af_in,
	output logic [7:0]      result,
	output logic            cf,
	output logic            af
);

	// Adjust needed on the low and high digit
	logic       low_adj;
	logic       high_adj;
	// Byte after the low digit correction
	logic [7:0] low_sum;

	// --------------------
	// Low digit
	// --------------------

	// Digit out of BCD range, or a carry left the nibble earlier
	assign low_adj = (al[3:0] > 4'd9) || af_in;
	assign low_sum = low_adj ? al + 8'h06 : al;

	// --------------------
	// High digit
	// --------------------

	// Tested on the original byte, not the low-corrected one
	assign high_adj = (al > 8'h99) || cf_in;
	assign result   = high_adj ? low_sum + 8'h60 : low_sum;

	// Decimal carries out
	assign af = low_adj;
	assign cf = high_adj;

endmodule

`default_nettype wire

/* hw/alu32.sv */
`default_nettype none

module alu32 (
	alu_if.alu alu
);
	import alu_pkg::*;

	// Logic op results
	logic [31:0] and_res;
	logic [31:0] or_res;
	logic [31:0] not_res;
	// Adder outputs
	logic [31:0] arith_sum;
	logic        arith_cf;
	logic        arith_af;
	logic        arith_of;
	// Decimal adjust outputs
	logic [7:0]  daa_res;
	logic        daa_cf;
	logic        daa_af;
	// Size used for SF and ZF, byte for DAA
	data_size_t  flag_size;
	logic        res_sf;
	logic        res_zf;
	logic        res_pf;

	// --------------------
	// Datapath
	// --------------------

	assign and_res = alu.a & alu.b;
	assign or_res  = alu.a | alu.b;
	assign not_res = ~alu.a;

	// CMP is the only op that subtracts
	alu_arith u_arith (
		.a        (alu.a),
		.b        (alu.b),
		.subtract (alu.op == OP_CMP),
		.size     (alu.size),
		.sum      (arith_sum),
		.cf       (arith_cf),
		.af       (arith_af),
		.of       (arith_of)
	);

	// Adjusts AL using carries from the previous op
	alu_daa u_daa (
		.al     (alu.a[7:0]),
		.cf_in  (alu.cf_in),
		.af_in  (alu.af_in),
		.result (daa_res),
		.cf     (daa_cf),
		.af     (daa_af)
	);

	always_comb begin
		case (alu.op)
			OP_ADD, OP_CMP: alu.result = arith_sum;
			OP_OR:          alu.result = or_res;
			OP_NOT:         alu.result = not_res;
			OP_AND:         alu.result = and_res;
			OP_DAA:         alu.result = {24'd0, daa_res};
			// CLD and STD only touch flags
			default:        alu.result = 32'd0;
		endcase
	end

	// --------------------
	// Result flags
	// --------------------

	assign flag_size = (alu.op == OP_DAA) ? SZ_BYTE : alu.size;

	always_comb begin
		case (flag_size)
			SZ_BYTE: begin
				res_sf = alu.result[7];
				res_zf = (alu.result[7:0] == 8'd0);
			end
			SZ_WORD: begin
				res_sf = alu.result[15];
				res_zf = (alu.result[15:0] == 16'd0);
			end
			default: begin
				res_sf = alu.result[31];
				res_zf = (alu.result == 32'd0);
			end
		endcase
	end

	// Even parity over the low byte only
	assign res_pf = ~^alu.result[7:0];

	// Flag word per op, unused bits stay zero
	always_comb begin
		alu.flags          = 32'd0;
		alu.flags[FLAG_DF] = alu.flags_in[FLAG_DF];
		case (alu.op)
			OP_ADD, OP_CMP: begin
				alu.flags[FLAG_CF] = arith_cf;
				alu.flags[FLAG_AF] = arith_af;
				alu.flags[FLAG_OF] = arith_of;
				alu.flags[FLAG_SF] = res_sf;
				alu.flags[FLAG_ZF] = res_zf;
				alu.flags[FLAG_PF] = res_pf;
			end
			OP_AND, OP_OR: begin
				alu.flags[FLAG_SF] = res_sf;
				alu.flags[FLAG_ZF] = res_zf;
				alu.flags[FLAG_PF] = res_pf;
			end
			OP_DAA: begin
				// BCD is unsigned so SF and OF stay clear
				alu.flags[FLAG_CF] = daa_cf;
				alu.flags[FLAG_AF] = daa_af;
				alu.flags[FLAG_ZF] = res_zf;
				alu.flags[FLAG_PF] = res_pf;
			end
			OP_NOT: alu.flags = alu.flags_in;
			OP_CLD: begin
				alu.flags          = alu.flags_in;
				alu.flags[FLAG_DF] = 1'b0;
			end
			default: begin
				// STD
				alu.flags          = alu.flags_in;
				alu.flags[FLAG_DF] = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/exe_stage.sv */
`default_nettype none

module exe_stage (
	input  wire logic  clk,
	input  wire logic  reset,
	exe_req_if.sink    req,
	output logic       out_valid,
	input  wire logic  out_ready,
	output logic [31:0] out_result,
	output logic [31:0] out_flags
);
	import alu_pkg::*;

	// Handshake on the request side
	logic        accept;
	// Architectural flags register
	logic [31:0] flags_q;

	// ALU bus
	alu_if alu_bus ();

	// --------------------
	// Input handshake
	// --------------------

	// Free when empty or being drained this cycle
	assign req.ready = ~out_valid | out_ready;
	assign accept    = req.valid & req.ready;

	// --------------------
	// ALU
	// --------------------

	assign alu_bus.op       = req.payload.op;
	assign alu_bus.size     = req.payload.size;
	assign alu_bus.a        = req.payload.a;
	assign alu_bus.b        = req.payload.b;
	assign alu_bus.cf_in    = flags_q[FLAG_CF];
	assign alu_bus.af_in    = flags_q[FLAG_AF];
	assign alu_bus.flags_in = flags_q;

	alu32 u_alu (
		.alu (alu_bus.alu)
	);

	// --------------------
	// Flags and output slot
	// --------------------

	// Flags update at acceptance so the next request sees them
	always_ff @(posedge clk) begin
		if (reset) begin
			flags_q   <= 32'd0;
			out_valid <= 1'b0;
		end else begin
			if (accept) begin
				flags_q   <= alu_bus.flags;
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_result <= alu_bus.result;
		end
	end

	// Flags register only moves on accept, which only happens when the slot
	// is free, so it also serves as the flags half of the output slot
	assign out_flags = flags_q;

	// --------------------
	// Assertions
	// --------------------

	// Stalled output holds its contents
	a_slot_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_flags));

	// Illegal size never enters the stage
	a_size_legal: assert property (@(posedge clk) disable iff (reset)
		accept |-> req.payload.size != 2'd3);

	// Slot empty right after reset
	a_reset_empty: assert property (@(posedge clk)
		reset |=> !out_valid);

endmodule

`default_nettype wire

/* hw/exe_top.sv */
`default_nettype none

module exe_top (
	input  wire logic               clk,
	input  wire logic               reset,
	// Request side
	input  wire logic               in_valid,
	output logic                    in_ready,
	input  wire alu_pkg::alu_op_t   in_op,
	input  wire alu_pkg::data_size_t in_size,
	input  wire logic [31:0]        in_a,
	input  wire logic [31:0]        in_b,
	// Result side
	output logic                    out_valid,
	input  wire logic               out_ready,
	output logic [31:0]             out_result,
	output logic [31:0]             out_flags
);

	// Request channel into the stage
	exe_req_if u_req_if (
		.clk (clk)
	);

	// --------------------
	// Pack plain ports
	// --------------------

	assign u_req_if.valid        = in_valid;
	assign u_req_if.payload.op   = in_op;
	assign u_req_if.payload.size = in_size;
	assign u_req_if.payload.a    = in_a;
	assign u_req_if.payload.b    = in_b;
	assign in_ready              = u_req_if.ready;

	// Execute stage
	exe_stage u_stage (
		.clk        (clk),
		.reset      (reset),
		.req        (u_req_if.sink),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result),
		.out_flags  (out_flags)
	);

endmodule

`default_nettype wire

/* testbench/tb_exe_top.sv */
`default_nettype none

module tb_exe_top;
	import alu_pkg::*;

	localparam int TIMEOUT = 200;

	// DUT ports
	logic        clk;
	logic        reset;
	logic        in_valid;
	logic        in_ready;
	alu_op_t     in_op;
	data_size_t  in_size;
	logic [31:0] in_a;
	logic [31:0] in_b;
	logic        out_valid;
	logic        out_ready;
	logic [31:0] out_result;
	logic [31:0] out_flags;

	// Bookkeeping
	int          errors;
	int          err_mark;
	int          tests_pass;
	int          tests_fail;
	int          sent;
	int          out_count;
	logic        stall_mode;
	logic [31:0] lfsr_state;
	// Requests accepted but not yet seen at the output
	exe_req_t    pend[$];
	exe_req_t    acc_req;
	exe_req_t    cmp_req;
	logic [63:0] cmp_exp;
	// Model flags register, follows the output stream
	logic [31:0] model_flags;
	// Most recent output transfer
	logic [31:0] last_result;
	logic [31:0] last_flags;
	// Stall tracking for the stability check
	logic        held;
	logic [31:0] prev_result;
	logic [31:0] prev_flags;

	exe_top u_dut (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_size    (in_size),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result),
		.out_flags  (out_flags)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------
	// Helpers
	// --------------------

	// Right-shift Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			else
				lfsr_state = lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Expected {flags, result} from the ALU rules
	function automatic logic [63:0] ref_alu(input exe_req_t r, input logic [31:0] fl);
		int          w;
		logic [31:0] mask;
		logic [32:0] wide;
		logic [31:0] res;
		logic [31:0] f;
		logic [7:0]  al;
		logic        lo;
		logic        hi;
		case (r.size)
			SZ_BYTE: w = 8;
			SZ_WORD: w = 16;
			default: w = 32;
		endcase
		mask = (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
		res  = 32'd0;
		f    = 32'd0;
		// DF survives everything except CLD and STD
		f[FLAG_DF] = fl[FLAG_DF];
		case (r.op)
			OP_ADD: begin
				res        = r.a + r.b;
				wide       = {1'b0, r.a & mask} + {1'b0, r.b & mask};
				f[FLAG_CF] = wide[w];
				f[FLAG_AF] = ({1'b0, r.a[3:0]} + {1'b0, r.b[3:0]}) > 5'd15;
				f[FLAG_OF] = (r.a[w-1] == r.b[w-1]) && (res[w-1] != r.a[w-1]);
			end
			OP_CMP: begin
				res        = r.a - r.b;
				f[FLAG_CF] = (r.a & mask) < (r.b & mask);
				f[FLAG_AF] = r.a[3:0] < r.b[3:0];
				// Overflow on subtract needs opposite operand signs
				f[FLAG_OF] = (r.a[w-1] != r.b[w-1]) && (res[w-1] != r.a[w-1]);
			end
			OP_AND: res = r.a & r.b;
			OP_OR:  res = r.a | r.b;
			OP_NOT: res = ~r.a;
			OP_DAA: begin
				al         = r.a[7:0];
				lo         = (al[3:0] > 4'd9) || fl[FLAG_AF];
				hi         = (al > 8'h99) || fl[FLAG_CF];
				res        = {24'd0, al + (lo ? 8'h06 : 8'h00) + (hi ? 8'h60 : 8'h00)};
				f[FLAG_CF] = hi;
				f[FLAG_AF] = lo;
				w          = 8;
				mask       = 32'hFF;
			end
			default: ;
		endcase
		if (r.op == OP_ADD || r.op == OP_CMP || r.op == OP_AND || r.op == OP_OR) begin
			f[FLAG_SF] = res[w-1];
			f[FLAG_ZF] = (res & mask) == 32'd0;
			f[FLAG_PF] = ~^res[7:0];
		end else if (r.op == OP_DAA) begin
			f[FLAG_ZF] = res[7:0] == 8'd0;
			f[FLAG_PF] = ~^res[7:0];
		end else if (r.op == OP_NOT) begin
			f = fl;
		end else begin
			f          = fl;
			f[FLAG_DF] = (r.op == OP_STD);
		end
		return {f, res};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("Something failed");
		$finish;
	endtask

	// Drive one request and wait for its accepting edge
	task automatic send(input alu_op_t op, input data_size_t sz,
			input logic [31:0] a, input logic [31:0] b);
		int t;
		in_valid <= 1'b1;
		in_op    <= op;
		in_size  <= sz;
		in_a     <= a;
		in_b     <= b;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!in_ready && t < TIMEOUT);
		if (!in_ready)
			abort_run("request was never accepted");
		else
			sent++;
	endtask

	// Drop valid and wait until every request has come out
	task automatic drain();
		int t;
		in_valid <= 1'b0;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (out_count < sent && t < TIMEOUT);
		if (out_count < sent)
			abort_run("outputs did not drain");
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			$display("%s: pass", name);
			tests_pass++;
		end else begin
			$display("%s: fail", name);
			tests_fail++;
		end
		err_mark = errors;
	endtask

	// --------------------
	// Back-pressure driver
	// --------------------

	always @(posedge clk) begin
		out_ready <= stall_mode ? (rand_bits(1) != 32'd0) : 1'b1;
	end

	// --------------------
	// Compare process
	// --------------------

	always @(posedge clk) begin
		if (reset) begin
			model_flags = 32'd0;
			held        = 1'b0;
		end else begin
			if (in_valid && in_ready) begin
				acc_req.op   = in_op;
				acc_req.size = in_size;
				acc_req.a    = in_a;
				acc_req.b    = in_b;
				pend.push_back(acc_req);
			end
			// Stalled slot must not move
			if (held) begin
				check("out_result while stalled", out_result, prev_result);
				check("out_flags while stalled", out_flags, prev_flags);
			end
			if (out_valid && out_ready) begin
				if (pend.size() == 0) begin
					$display("An output appeared with no request pending");
					errors++;
				end else begin
					cmp_req = pend.pop_front();
					cmp_exp = ref_alu(cmp_req, model_flags);
					check("out_result", out_result, cmp_exp[31:0]);
					check("out_flags", out_flags, cmp_exp[63:32]);
					model_flags = cmp_exp[63:32];
				end
				last_result = out_result;
				last_flags  = out_flags;
				out_count++;
			end
			held        = out_valid && !out_ready;
			prev_result = out_result;
			prev_flags  = out_flags;
		end
	end

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] f0;
		logic [31:0] mask;
		logic [7:0]  exp_bcd;
		int          d[4];
		int          dec;
		errors     = 0;
		err_mark   = 0;
		tests_pass = 0;
		tests_fail = 0;
		sent       = 0;
		out_count  = 0;
		stall_mode = 1'b0;
		lfsr_state = 32'd36;
		reset      = 1'b1;
		in_valid   = 1'b0;
		in_op      = OP_ADD;
		in_size    = SZ_BYTE;
		in_a       = 32'd0;
		in_b       = 32'd0;
		out_ready  = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Empty slot and cleared flags
		check("out_valid", out_valid, 32'd0);
		check("in_ready", in_ready, 32'd1);
		send(OP_NOT, SZ_DWORD, rand_bits(32), 32'd0);
		drain();
		check("out_flags", last_flags, 32'd0);
		end_test("reset state");

		// Edge values per size, then random ADD and CMP
		for (int s = 0; s < 3; s++) begin
			mask = (s == 0) ? 32'hFF : ((s == 1) ? 32'hFFFF : 32'hFFFF_FFFF);
			send(OP_ADD, data_size_t'(s), mask >> 1, 32'd1);
			send(OP_ADD, data_size_t'(s), mask, 32'd1);
			x = rand_bits(32);
			send(OP_CMP, data_size_t'(s), x, x);
			send(OP_CMP, data_size_t'(s), 32'd0, 32'd1);
		end
		for (int i = 0; i < 24; i++) begin
			send((rand_bits(1) != 0) ? OP_CMP : OP_ADD, data_size_t'(rand_bits(2) % 3),
				rand_bits(32), rand_bits(32));
		end
		drain();
		end_test("add and cmp");

		// Logic ops, then NOT keeps the flags of an ADD
		// Byte add that sets CF, AF and OF ahead of the logic ops
		send(OP_ADD, SZ_BYTE, 32'h88, 32'h88);
		for (int i = 0; i < 16; i++) begin
			x = rand_bits(2) % 3;
			send((x == 0) ? OP_AND : ((x == 1) ? OP_OR : OP_NOT),
				data_size_t'(rand_bits(2) % 3), rand_bits(32), rand_bits(32));
		end
		send(OP_ADD, SZ_BYTE, 32'hFF, 32'd1);
		drain();
		f0 = model_flags;
		send(OP_NOT, SZ_DWORD, rand_bits(32), 32'd0);
		drain();
		check("out_flags after NOT", last_flags, f0);
		end_test("logic ops");

		// Packed BCD add through ADD then DAA
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 4; k++)
				d[k] = rand_bits(4) % 10;
			x   = d[1] * 16 + d[0];
			y   = d[3] * 16 + d[2];
			dec = d[1] * 10 + d[0] + d[3] * 10 + d[2];
			send(OP_ADD, SZ_BYTE, x, y);
			send(OP_DAA, SZ_BYTE, (x + y) & 32'hFF, 32'd0);
			drain();
			exp_bcd = ((dec % 100) / 10) * 16 + dec % 10;
			check("daa result", last_result, {24'd0, exp_bcd});
			check("decimal carry", {31'd0, last_flags[FLAG_CF]}, dec >= 100);
		end
		end_test("bcd add");

		// DF set, kept through other ops, then cleared
		f0 = model_flags;
		send(OP_STD, SZ_DWORD, 32'd0, 32'd0);
		drain();
		check("out_flags after STD", last_flags, f0 | (32'd1 << FLAG_DF));
		send(OP_ADD, SZ_DWORD, rand_bits(32), rand_bits(32));
		drain();
		check("DF after ADD", {31'd0, last_flags[FLAG_DF]}, 32'd1);
		send(OP_AND, SZ_WORD, rand_bits(32), rand_bits(32));
		drain();
		check("DF after AND", {31'd0, last_flags[FLAG_DF]}, 32'd1);
		send(OP_DAA, SZ_BYTE, rand_bits(32), 32'd0);
		drain();
		check("DF after DAA", {31'd0, last_flags[FLAG_DF]}, 32'd1);
		f0 = model_flags;
		send(OP_CLD, SZ_DWORD, 32'd0, 32'd0);
		drain();
		check("out_flags after CLD", last_flags, f0 & ~(32'd1 << FLAG_DF));
		end_test("direction flag");

		// Back-to-back requests against random out_ready
		stall_mode <= 1'b1;
		for (int i = 0; i < 40; i++) begin
			send(alu_op_t'(rand_bits(3)), data_size_t'(rand_bits(2) % 3),
				rand_bits(32), rand_bits(32));
		end
		drain();
		stall_mode <= 1'b0;
		check("pending requests", pend.size(), 32'd0);
		check("output count", out_count, sent);
		end_test("back-pressure");

		$display("Tests passed %0d, failed %0d, check errors %0d",
			tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
hw/alu_pkg.sv
hw/exe_if.sv
hw/alu_arith.sv
hw/alu_daa.sv
hw/alu32.sv
hw/exe_stage.sv
hw/exe_top.sv
testbench/tb_exe_top.sv
